/* compile.f */
+incdir+logic
logic/csr_pkg.sv
logic/csr_unit.sv
logic/pmp_unit.sv
logic/csr_subsys_top.sv
sim/csr_subsys_tb.sv

/* logic/csr_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr subsystem types
// command, access kind and pmp
// address match mode encodings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package csr_pkg;

    // how the write data combines with the current csr value
    typedef enum logic [1:0]
    {
        CSR_NONE = 2'b00,   // no operation
        CSR_WR   = 2'b01,   // plain write
        CSR_SET  = 2'b10,   // old | data
        CSR_CLR  = 2'b11    // old & ~data
    } csr_cmd_t;

    // kind of memory access being scanned
    typedef enum logic [1:0]
    {
        ACC_EXEC  = 2'b00,  // instruction fetch
        ACC_LOAD  = 2'b01,  // data read
        ACC_STORE = 2'b10   // data write
    } acc_kind_t;

    // A field of a pmp entry config, bits 4:3
    typedef enum logic [1:0]
    {
        PMP_OFF   = 2'b00,  // entry disabled
        PMP_TOR   = 2'b01,  // top of range
        PMP_NA4   = 2'b10,  // naturally aligned word
        PMP_NAPOT = 2'b11   // not implemented, never matches
    } pmp_mode_t;

endpackage : csr_pkg

/* logic/csr_settings.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr subsystem settings
// csr addresses, misa value, trap cause codes
// and pmp geometry for the csr and pmp units
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// user level registers
`define USTATUS_A           12'h000     // user status
`define UIE_A               12'h004     // user interrupt enable
`define UTVEC_A             12'h005     // user trap vector base

// supervisor trap registers
`define SEPC_A              12'h141     // supervisor exception pc
`define SCAUSE_A            12'h142     // supervisor trap cause

// machine level registers
`define MISA_A              12'h301     // isa and extensions, read only
`define MCYCLE_A            12'hB00     // cycle counter, low word

// pmp register runs
`define PMPCFG0_A           12'h3A0     // first of 4 config words
`define PMPADDR0_A          12'h3B0     // first of 16 address regs

// rv32, base integer isa only
`define MISA_V              32'h4000_0100

// access fault causes
`define CAUSE_INST_FAULT    32'h0000_0001   // execute
`define CAUSE_LOAD_FAULT    32'h0000_0005   // load
`define CAUSE_STORE_FAULT   32'h0000_0007   // store

// pmp geometry
`define PMP_ENTRIES         16          // one config byte each
`define PMP_CFG_WORDS       4           // four entry bytes per word

// permission bits inside an entry config byte
`define PMP_R_BIT           0           // read
`define PMP_W_BIT           1           // write
`define PMP_X_BIT           2           // execute

`endif

/* logic/csr_subsys_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr subsystem top
// csr unit fronting the pmp unit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module csr_subsys_top
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    // csr port
    input  logic [11:0] csr_addr_i,
    input  csr_cmd_t    csr_cmd_i,
    input  logic [31:0] csr_wd_i,
    input  logic        csr_wreq_i,
    input  logic        csr_rreq_i,
    output logic [31:0] csr_rd_o,
    // scan port
    input  logic        scan_valid_i,
    input  logic [31:0] scan_addr_i,
    input  acc_kind_t   scan_acc_i,
    output logic        pmp_err_o
);

    logic [11:0] pmp_addr;
    logic [31:0] pmp_wd;
    logic        pmp_wreq;
    logic        pmp_rreq;
    logic [31:0] pmp_rd;

    csr_unit csr_unit_i
    (
        .clk         ( clk          ),
        .resetn      ( resetn       ),
        .csr_addr_i  ( csr_addr_i   ),
        .csr_cmd_i   ( csr_cmd_i    ),
        .csr_wd_i    ( csr_wd_i     ),
        .csr_wreq_i  ( csr_wreq_i   ),
        .csr_rreq_i  ( csr_rreq_i   ),
        .csr_rd_o    ( csr_rd_o     ),
        .pmp_addr_o  ( pmp_addr     ),
        .pmp_wd_o    ( pmp_wd       ),
        .pmp_wreq_o  ( pmp_wreq     ),
        .pmp_rreq_o  ( pmp_rreq     ),
        .pmp_rd_i    ( pmp_rd       ),
        .pmp_err_i   ( pmp_err_o    ),  // same flag seen outside
        .scan_addr_i ( scan_addr_i  ),
        .scan_acc_i  ( scan_acc_i   )
    );

    pmp_unit pmp_unit_i
    (
        .clk          ( clk          ),
        .resetn       ( resetn       ),
        .pmp_addr_i   ( pmp_addr     ),
        .pmp_wd_i     ( pmp_wd       ),
        .pmp_wreq_i   ( pmp_wreq     ),
        .pmp_rreq_i   ( pmp_rreq     ),
        .pmp_rd_o     ( pmp_rd       ),
        .scan_valid_i ( scan_valid_i ),
        .scan_addr_i  ( scan_addr_i  ),
        .scan_acc_i   ( scan_acc_i   ),
        .pmp_err_o    ( pmp_err_o    )
    );

endmodule : csr_subsys_top

/* logic/csr_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr unit
// user and trap registers, mcycle, misa,
// write/set/clear resolution and the pass
// through of all other csr accesses to pmp
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    // csr port from execute stage
    input  logic [11:0] csr_addr_i,
    input  csr_cmd_t    csr_cmd_i,
    input  logic [31:0] csr_wd_i,
    input  logic        csr_wreq_i,
    input  logic        csr_rreq_i,
    output logic [31:0] csr_rd_o,
    // pmp register port
    output logic [11:0] pmp_addr_o,
    output logic [31:0] pmp_wd_o,
    output logic        pmp_wreq_o,
    output logic        pmp_rreq_o,
    input  logic [31:0] pmp_rd_i,
    // trap capture
    input  logic        pmp_err_i,
    input  logic [31:0] scan_addr_i,
    input  acc_kind_t   scan_acc_i
);

    logic [31:0] ustatus;
    logic [31:0] uie;
    logic [31:0] utvec;
    logic [31:0] sepc;
    logic [31:0] scause;
    logic [31:0] mcycle;
    logic [31:0] local_rd;      // value of a local register
    logic        local_hit;     // address claimed locally
    logic [31:0] rd_int;        // current value at csr_addr_i
    logic [31:0] wd_int;        // command-resolved write data
    logic [31:0] trap_cause;

    // everything not claimed here is handed to pmp
    assign pmp_addr_o = csr_addr_i;
    assign pmp_wd_o   = wd_int;
    assign pmp_wreq_o = csr_wreq_i;
    assign pmp_rreq_o = csr_rreq_i;

    always_comb
    begin
        local_hit = 1'b1;
        local_rd  = '0;
        case (csr_addr_i)
            `USTATUS_A : local_rd = ustatus;
            `UIE_A     : local_rd = uie;
            `UTVEC_A   : local_rd = utvec;
            `SEPC_A    : local_rd = sepc;
            `SCAUSE_A  : local_rd = scause;
            `MCYCLE_A  : local_rd = mcycle;
            `MISA_A    : local_rd = `MISA_V;    // constant, writes dropped
            default    : local_hit = 1'b0;
        endcase
    end

    assign rd_int   = local_hit ? local_rd : pmp_rd_i;  // pmp gives 0 off its range
    assign csr_rd_o = rd_int;

    always_comb
    begin
        case (csr_cmd_i)
            CSR_SET : wd_int = rd_int | csr_wd_i;
            CSR_CLR : wd_int = rd_int & ~csr_wd_i;
            default : wd_int = csr_wd_i;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            ustatus <= '0;
            uie     <= '0;
            utvec   <= '0;
        end
        else if (csr_wreq_i)
        begin
            case (csr_addr_i)
                `USTATUS_A : ustatus <= wd_int;
                `UIE_A     : uie     <= wd_int;
                `UTVEC_A   : utvec   <= wd_int;
                default    : ;                      // not a user register
            endcase
        end
    end

    // free running, a csr write loads it instead of the increment
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            mcycle <= '0;
        else if (csr_wreq_i && (csr_addr_i == `MCYCLE_A))
            mcycle <= wd_int;
        else
            mcycle <= mcycle + 32'd1;
    end

    always_comb
    begin
        case (scan_acc_i)
            ACC_LOAD  : trap_cause = `CAUSE_LOAD_FAULT;
            ACC_STORE : trap_cause = `CAUSE_STORE_FAULT;
            default   : trap_cause = `CAUSE_INST_FAULT;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            sepc   <= '0;
            scause <= '0;
        end
        else if (pmp_err_i)
        begin
            sepc   <= scan_addr_i;  // faulting address
            scause <= trap_cause;
        end
    end

    // the execute stage only strobes a write for a real command
    a_wreq_has_cmd : assert property (
        @(posedge clk) disable iff (!resetn)
        csr_wreq_i |-> (csr_cmd_i != CSR_NONE)
    ) else $error("csr write strobe with CSR_NONE");

endmodule : csr_unit

/* logic/pmp_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pmp unit
// config and address registers behind the
// csr port, plus the OFF/TOR/NA4 region
// check of the scan address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "csr_settings.svh"

module pmp_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    // register port from csr_unit
    input  logic [11:0] pmp_addr_i,
    input  logic [31:0] pmp_wd_i,
    input  logic        pmp_wreq_i,
    input  logic        pmp_rreq_i,
    output logic [31:0] pmp_rd_o,
    // scan port
    input  logic        scan_valid_i,
    input  logic [31:0] scan_addr_i,
    input  acc_kind_t   scan_acc_i,
    output logic        pmp_err_o
);

    logic [31:0]             pmpcfg  [`PMP_CFG_WORDS];
    logic [31:0]             pmpaddr [`PMP_ENTRIES];
    logic [11:0]             cfg_off;       // offset into the config run
    logic [11:0]             addr_off;      // offset into the address run
    logic                    cfg_hit;
    logic                    addr_hit;
    logic [31:0]             sel_rd;
    logic [7:0]              ent_cfg;       // config byte of the entry in the loop
    logic [31:0]             prev_top;      // TOR base, top of the entry below
    logic [31:0]             cur_top;
    logic [`PMP_ENTRIES-1:0] ent_match;
    logic [`PMP_ENTRIES-1:0] ent_perm;
    logic                    hit_found;
    logic                    hit_allow;

    assign cfg_off  = pmp_addr_i - `PMPCFG0_A;
    assign addr_off = pmp_addr_i - `PMPADDR0_A;
    assign cfg_hit  = (cfg_off < `PMP_CFG_WORDS);
    assign addr_hit = (addr_off < `PMP_ENTRIES);

    always_comb
    begin
        sel_rd = '0;
        if (cfg_hit)
            sel_rd = pmpcfg[cfg_off[1:0]];
        else if (addr_hit)
            sel_rd = pmpaddr[addr_off[3:0]];
    end

    // write also needs the old value for set/clear
    assign pmp_rd_o = (pmp_rreq_i || pmp_wreq_i) ? sel_rd : '0;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < `PMP_CFG_WORDS; i++)
                pmpcfg[i] <= '0;            // all entries OFF
            for (int i = 0; i < `PMP_ENTRIES; i++)
                pmpaddr[i] <= '0;
        end
        else if (pmp_wreq_i)
        begin
            if (cfg_hit)
                pmpcfg[cfg_off[1:0]] <= pmp_wd_i;
            if (addr_hit)
                pmpaddr[addr_off[3:0]] <= pmp_wd_i;
        end
    end

    // per entry match and permission for this access kind
    always_comb
    begin
        prev_top = '0;
        cur_top  = '0;
        ent_cfg  = '0;
        for (int i = 0; i < `PMP_ENTRIES; i++)
        begin
            ent_cfg = pmpcfg[i / 4][8 * (i % 4) +: 8];
            cur_top = {pmpaddr[i][29:0], 2'b00};    // pmpaddr holds addr >> 2
            case (pmp_mode_t'(ent_cfg[4:3]))
                PMP_TOR : ent_match[i] = (scan_addr_i >= prev_top) && (scan_addr_i < cur_top);
                PMP_NA4 : ent_match[i] = (scan_addr_i[31:2] == pmpaddr[i][29:0]);
                default : ent_match[i] = 1'b0;      // OFF, NAPOT unsupported
            endcase
            case (scan_acc_i)
                ACC_LOAD  : ent_perm[i] = ent_cfg[`PMP_R_BIT];
                ACC_STORE : ent_perm[i] = ent_cfg[`PMP_W_BIT];
                default   : ent_perm[i] = ent_cfg[`PMP_X_BIT];
            endcase
            prev_top = cur_top;
        end
    end

    // lowest numbered match wins
    always_comb
    begin
        hit_found = 1'b0;
        hit_allow = 1'b1;       // no match means allowed
        for (int i = 0; i < `PMP_ENTRIES; i++)
        begin
            if (ent_match[i] && !hit_found)
            begin
                hit_found = 1'b1;
                hit_allow = ent_perm[i];
            end
        end
    end

    assign pmp_err_o = scan_valid_i && hit_found && !hit_allow;

endmodule : pmp_unit

/* run_sim.sh */
#!/usr/bin/env bash
# build the csr subsystem testbench with verilator, run it,
# and decide the result from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module csr_subsys_tb \
    -Mdir obj_dir \
    -o csr_subsys_sim \
    && ./obj_dir/csr_subsys_sim | tee sim.log

grep -qF '*** PASSED ***' sim.log \
    && echo "result: simulation passed" \
    && exit 0 \
    || { echo "result: simulation failed, see sim.log"; exit 1; }

/* sim/csr_subsys_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr subsystem testbench
// table driven csr and pmp scan steps,
// checked against a reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_subsys_tb
    import csr_pkg::*;
();

    typedef struct packed
    {
        logic [11:0] addr;
        csr_cmd_t    cmd;
        logic [31:0] wd;
        logic        wreq;
        logic        scan_valid;
        logic [31:0] scan_addr;
        acc_kind_t   scan_acc;
        logic        chk_rd;        // read value is known
        logic [31:0] exp_rd;
        logic        exp_err;
    } step_t;

    logic        clk;
    logic        resetn;
    logic [11:0] csr_addr;
    csr_cmd_t    csr_cmd;
    logic [31:0] csr_wd;
    logic        csr_wreq;
    logic        csr_rreq;
    logic [31:0] csr_rd;
    logic        scan_valid;
    logic [31:0] scan_addr;
    acc_kind_t   scan_acc;
    logic        pmp_err;

    step_t       steps[$];
    int          errors;
    int          cycles;
    int          limit;

    // reference model state
    logic [31:0] m_ustatus;
    logic [31:0] m_uie;
    logic [31:0] m_utvec;
    logic [31:0] m_sepc;
    logic [31:0] m_scause;
    logic [31:0] m_mcycle;
    logic [31:0] m_cfg  [4];
    logic [31:0] m_addr [16];

    csr_subsys_top csr_subsys_top_i
    (
        .clk          ( clk        ),
        .resetn       ( resetn     ),
        .csr_addr_i   ( csr_addr   ),
        .csr_cmd_i    ( csr_cmd    ),
        .csr_wd_i     ( csr_wd     ),
        .csr_wreq_i   ( csr_wreq   ),
        .csr_rreq_i   ( csr_rreq   ),
        .csr_rd_o     ( csr_rd     ),
        .scan_valid_i ( scan_valid ),
        .scan_addr_i  ( scan_addr  ),
        .scan_acc_i   ( scan_acc   ),
        .pmp_err_o    ( pmp_err    )
    );

    always #20 clk = ~clk;      // 40 ns period

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] expect_read(input logic [11:0] a);
        logic [31:0] v;
        v = 32'h0;
        if (a == `USTATUS_A)
            v = m_ustatus;
        else if (a == `UIE_A)
            v = m_uie;
        else if (a == `UTVEC_A)
            v = m_utvec;
        else if (a == `SEPC_A)
            v = m_sepc;
        else if (a == `SCAUSE_A)
            v = m_scause;
        else if (a == `MCYCLE_A)
            v = m_mcycle;
        else if (a == `MISA_A)
            v = `MISA_V;
        else if (a >= `PMPCFG0_A && a < `PMPCFG0_A + 12'd4)
            v = m_cfg[a[1:0]];      // run starts on a multiple of 4
        else if (a >= `PMPADDR0_A && a < `PMPADDR0_A + 12'd16)
            v = m_addr[a[3:0]];     // run starts on a multiple of 16
        return v;
    endfunction

    // lowest matching entry decides, no match allows
    function automatic logic region_fault(input logic [31:0] sa, input acc_kind_t acc);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [7:0]  cfg;
        logic [3:0]  e;
        logic        matched;
        logic        decided;
        logic        fault;
        lo      = 32'h0;
        decided = 1'b0;
        fault   = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            e   = i[3:0];
            cfg = m_cfg[e[3:2]][{e[1:0], 3'b000} +: 8];
            hi  = m_addr[e] << 2;
            case (cfg[4:3])
                2'b01   : matched = (sa >= lo) && (sa < hi);
                2'b10   : matched = ((sa & ~32'h3) == hi);
                default : matched = 1'b0;
            endcase
            if (matched && !decided)
            begin
                decided = 1'b1;
                case (acc)
                    ACC_LOAD  : fault = !cfg[0];
                    ACC_STORE : fault = !cfg[1];
                    default   : fault = !cfg[2];
                endcase
            end
            lo = hi;
        end
        return fault;
    endfunction

    // computes the expected response, then advances the model by one edge
    task automatic add_step(input logic [11:0] a, input csr_cmd_t cmd, input logic [31:0] wd,
                            input logic wreq, input logic sv, input logic [31:0] sa,
                            input acc_kind_t acc, input logic chk);
        step_t       s;
        logic [31:0] res;
        s.addr       = a;
        s.cmd        = cmd;
        s.wd         = wd;
        s.wreq       = wreq;
        s.scan_valid = sv;
        s.scan_addr  = sa;
        s.scan_acc   = acc;
        s.chk_rd     = chk;
        s.exp_rd     = expect_read(a);
        s.exp_err    = sv && region_fault(sa, acc);
        case (cmd)
            CSR_SET : res = s.exp_rd | wd;
            CSR_CLR : res = s.exp_rd & ~wd;
            default : res = wd;
        endcase
        if (wreq)
        begin
            if (a == `USTATUS_A)
                m_ustatus = res;
            else if (a == `UIE_A)
                m_uie = res;
            else if (a == `UTVEC_A)
                m_utvec = res;
            else if (a >= `PMPCFG0_A && a < `PMPCFG0_A + 12'd4)
                m_cfg[a[1:0]] = res;
            else if (a >= `PMPADDR0_A && a < `PMPADDR0_A + 12'd16)
                m_addr[a[3:0]] = res;
        end
        if (wreq && a == `MCYCLE_A)
            m_mcycle = res;
        else
            m_mcycle = m_mcycle + 32'd1;
        if (s.exp_err)
        begin
            m_sepc   = sa;
            m_scause = (acc == ACC_LOAD)  ? `CAUSE_LOAD_FAULT :
                       (acc == ACC_STORE) ? `CAUSE_STORE_FAULT : `CAUSE_INST_FAULT;
        end
        steps.push_back(s);
    endtask

    task automatic read_step(input logic [11:0] a);
        add_step(a, CSR_NONE, 32'h0, 1'b0, 1'b0, 32'h0, ACC_LOAD, 1'b1);
    endtask

    task automatic write_step(input logic [11:0] a, input csr_cmd_t cmd, input logic [31:0] wd);
        add_step(a, cmd, wd, 1'b1, 1'b0, 32'h0, ACC_LOAD, 1'b1);
    endtask

    task automatic scan_step(input logic [11:0] a, input logic [31:0] sa, input acc_kind_t acc);
        add_step(a, CSR_NONE, 32'h0, 1'b0, 1'b1, sa, acc, 1'b1);
    endtask

    task automatic rd_compare(input int idx, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("mismatch csr_rd_o step %0d: expected %h, actual %h", idx, exp, act);
        end
    endtask

    task automatic err_compare(input int idx, input logic exp, input logic act);
        if (act !== exp)
        begin
            errors++;
            $display("mismatch pmp_err_o step %0d: expected %h, actual %h", idx, exp, act);
        end
    endtask

    initial
    begin
        logic [11:0] user_regs[3];
        clk        = 1'b0;
        resetn     = 1'b0;
        csr_addr   = 12'h0;
        csr_cmd    = CSR_NONE;
        csr_wd     = 32'h0;
        csr_wreq   = 1'b0;
        csr_rreq   = 1'b0;
        scan_valid = 1'b0;
        scan_addr  = 32'h0;
        scan_acc   = ACC_EXEC;
        errors     = 0;
        cycles     = 0;
        m_ustatus  = 32'h0;
        m_uie      = 32'h0;
        m_utvec    = 32'h0;
        m_sepc     = 32'h0;
        m_scause   = 32'h0;
        m_mcycle   = 32'h0;
        for (int i = 0; i < 4; i++)
            m_cfg[i] = 32'h0;
        for (int i = 0; i < 16; i++)
            m_addr[i] = 32'h0;
        void'($urandom(32'd7801));
        user_regs = '{`USTATUS_A, `UIE_A, `UTVEC_A};

        // reset values, misa is read only
        read_step(`USTATUS_A);
        read_step(`UIE_A);
        read_step(`UTVEC_A);
        read_step(`SEPC_A);
        read_step(`SCAUSE_A);
        read_step(`PMPCFG0_A);
        read_step(`PMPCFG0_A + 12'd3);
        read_step(`PMPADDR0_A);
        read_step(`PMPADDR0_A + 12'd15);
        read_step(`MISA_A);
        scan_step(`USTATUS_A, 32'h0000_0100, ACC_EXEC);     // all entries OFF
        write_step(`MISA_A, CSR_WR, $urandom());
        read_step(`MISA_A);

        // write, set and clear on the user registers
        for (int r = 0; r < 3; r++)
        begin
            write_step(user_regs[r], CSR_WR, $urandom());
            read_step(user_regs[r]);
            write_step(user_regs[r], CSR_SET, $urandom());
            read_step(user_regs[r]);
            write_step(user_regs[r], CSR_CLR, $urandom());
            read_step(user_regs[r]);
        end
        read_step(12'h7C0);
        write_step(12'h7C0, CSR_WR, $urandom());
        read_step(12'h7C0);
        read_step(`PMPCFG0_A + 12'd4);      // just past each pmp run
        read_step(`PMPADDR0_A + 12'd16);

        // mcycle load, the load row itself reads an unknown count
        add_step(`MCYCLE_A, CSR_WR, $urandom(), 1'b1, 1'b0, 32'h0, ACC_LOAD, 1'b0);
        read_step(`MCYCLE_A);
        read_step(`MCYCLE_A);
        read_step(`MCYCLE_A);
        read_step(`USTATUS_A);
        read_step(`MCYCLE_A);

        // pmp registers through the csr port
        write_step(`PMPCFG0_A, CSR_WR, $urandom());
        read_step(`PMPCFG0_A);
        write_step(`PMPCFG0_A, CSR_SET, $urandom());
        read_step(`PMPCFG0_A);
        write_step(`PMPCFG0_A, CSR_CLR, $urandom());
        read_step(`PMPCFG0_A);
        for (int w = 1; w < 4; w++)
        begin
            write_step(`PMPCFG0_A + w[11:0], CSR_WR, $urandom());
            read_step(`PMPCFG0_A + w[11:0]);
        end
        write_step(`PMPADDR0_A + 12'd5, CSR_WR, $urandom());
        read_step(`PMPADDR0_A + 12'd5);
        write_step(`PMPADDR0_A + 12'd15, CSR_WR, $urandom());
        read_step(`PMPADDR0_A + 12'd15);
        for (int w = 0; w < 4; w++)
            write_step(`PMPCFG0_A + w[11:0], CSR_WR, 32'h0);

        // entry 0 TOR read only up to 0x1000, entries 1 and 2 NA4 no access
        write_step(`PMPADDR0_A, CSR_WR, 32'h0000_0400);
        write_step(`PMPADDR0_A + 12'd1, CSR_WR, 32'h0000_0800);     // word 0x2000
        write_step(`PMPADDR0_A + 12'd2, CSR_WR, 32'h0000_0100);     // word 0x400, inside TOR
        write_step(`PMPCFG0_A, CSR_WR, 32'h0010_1009);
        read_step(`PMPCFG0_A);

        scan_step(`SEPC_A, 32'h0000_0100, ACC_LOAD);
        scan_step(`SCAUSE_A, 32'h0000_0104, ACC_STORE);
        scan_step(`SEPC_A, 32'h0000_2004, ACC_LOAD);        // no entry matches
        scan_step(`SCAUSE_A, 32'h0000_1000, ACC_STORE);     // TOR top is exclusive
        scan_step(`SEPC_A, 32'h0000_0FFC, ACC_EXEC);
        scan_step(`SCAUSE_A, 32'h0000_2000, ACC_LOAD);
        scan_step(`SCAUSE_A, 32'h0000_2003, ACC_EXEC);      // load cause from the row above
        scan_step(`SCAUSE_A, 32'h0000_0400, ACC_LOAD);      // entry 0 wins over entry 2
        scan_step(`SEPC_A, 32'h0000_0404, ACC_LOAD);
        add_step(`SCAUSE_A, CSR_NONE, 32'h0, 1'b0, 1'b0, 32'h0000_2000, ACC_STORE, 1'b1);
        read_step(`SEPC_A);
        read_step(`SCAUSE_A);

        limit = steps.size() * 4 + 100;

        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        for (int n = 0; n < steps.size(); n++)
        begin
            @(posedge clk);
            csr_addr   <= steps[n].addr;
            csr_cmd    <= steps[n].cmd;
            csr_wd     <= steps[n].wd;
            csr_wreq   <= steps[n].wreq;
            csr_rreq   <= 1'b1;
            scan_valid <= steps[n].scan_valid;
            scan_addr  <= steps[n].scan_addr;
            scan_acc   <= steps[n].scan_acc;
            @(negedge clk);             // settled mid cycle
            if (steps[n].chk_rd)
                rd_compare(n, steps[n].exp_rd, csr_rd);
            err_compare(n, steps[n].exp_err, pmp_err);
        end
        @(posedge clk);
        csr_wreq   <= 1'b0;
        csr_cmd    <= CSR_NONE;
        scan_valid <= 1'b0;
        @(posedge clk);

        $display("%0d steps run, %0d errors", steps.size(), errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule : csr_subsys_tb
